// File: design/tdcHist_consts.svh
`ifndef TDC_HIST_CONSTS_SVH
`define TDC_HIST_CONSTS_SVH

// pixels sharing one histogram RAM
`define PIXEL_NUM 4

// time bin width, 64 bins per pixel
`define BIN_BITS 6

// bin counter width, saturates at all ones
`define COUNT_BITS 8

// enough bits to index PIXEL_NUM
`define PIXEL_BITS 2

// RAM address is {pixel, bin}
`define ADDR_BITS (`PIXEL_BITS + `BIN_BITS)

`endif

// File: design/tdcHistPkg.sv
`default_nettype none

`include "tdcHist_consts.svh"

package tdcHistPkg;

    // index vectors
    typedef logic [`PIXEL_BITS-1:0] pixelIdx_t;
    typedef logic [`BIN_BITS-1:0]   binIdx_t;
    typedef logic [`COUNT_BITS-1:0] count_t;

    // pixel in the upper bits, bin in the lower bits
    typedef logic [`ADDR_BITS-1:0]  histAddr_t;

    // one TDC event, valid for a single cycle
    typedef struct packed {
        logic      valid;
        pixelIdx_t pixel;
        binIdx_t   bin;
    } sample_t;

    // end-of-frame result for one pixel
    typedef struct packed {
        pixelIdx_t pixel;
        binIdx_t   bin;
        count_t    count;
    } peak_t;

endpackage

`default_nettype wire

// File: design/histCtrlPkg.sv
`default_nettype none

package histCtrlPkg;

    // one cycle of use of both RAM ports
    typedef struct packed {
        logic                  writeEn;
        tdcHistPkg::histAddr_t writeAddr;
        tdcHistPkg::count_t    writeData;
        logic                  readEn;
        tdcHistPkg::histAddr_t readAddr;
    } ramReq_t;

    // accumulation controller
    typedef enum logic [1:0] {
        updIdle,
        updAccumulating,
        updDraining,
        updScanning
    } updState_e;

    // clear sweep and peak scanner
    typedef enum logic [1:0] {
        scanClearing,
        scanIdle,
        scanScanning,
        scanReporting
    } scanState_e;

endpackage

`default_nettype wire

// File: design/histRam.sv
`timescale 1ns/100ps
`default_nettype none

`include "tdcHist_consts.svh"

module histRam (
    input  wire logic                 clk,
    input  wire histCtrlPkg::ramReq_t ramReq,
    output tdcHistPkg::count_t        readData
);

    // one counter per {pixel, bin}
    tdcHistPkg::count_t mem [0:(1 << `ADDR_BITS)-1];

    // write port
    always_ff @(posedge clk) begin
        if (ramReq.writeEn) begin
            mem[ramReq.writeAddr] <= ramReq.writeData;
        end
    end

    // read port, registered
    // same-address write in the same cycle gives the old value
    always_ff @(posedge clk) begin
        if (ramReq.readEn) begin
            readData <= mem[ramReq.readAddr];
        end
    end

endmodule

`default_nettype wire

// File: design/histUpdateFsm.sv
`timescale 1ns/100ps
`default_nettype none

module histUpdateFsm (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire tdcHistPkg::sample_t  sample,
    input  wire logic                 frameDone,
    input  wire tdcHistPkg::count_t   readData,
    input  wire histCtrlPkg::ramReq_t scanReq,
    input  wire logic                 scanBusy,
    output histCtrlPkg::ramReq_t      ramReq,
    output logic                      scanStart,
    output logic                      busy
);

    histCtrlPkg::updState_e state;
    logic                   drainCnt;

    logic                   accept;
    logic                   frameAccept;
    tdcHistPkg::histAddr_t  sampleAddr;

    // read stage, data comes back next cycle
    logic                   s1Valid;
    tdcHistPkg::histAddr_t  s1Addr;

    // write stage, goes to RAM this cycle
    logic                   s2Valid;
    tdcHistPkg::histAddr_t  s2Addr;
    tdcHistPkg::count_t     s2Data;

    // written last cycle, RAM read may have missed it
    logic                   s3Valid;
    tdcHistPkg::histAddr_t  s3Addr;
    tdcHistPkg::count_t     s3Data;

    tdcHistPkg::count_t     baseCount;
    tdcHistPkg::count_t     nextCount;
    histCtrlPkg::ramReq_t   ownReq;

    // drain, handoff cycle, then scanner's own busy
    assign busy = (state == histCtrlPkg::updDraining)
               || ((state == histCtrlPkg::updScanning) && scanStart)
               || scanBusy;

    // inputs while busy are dropped
    assign accept      = sample.valid && !busy;
    assign frameAccept = frameDone && !busy;
    assign sampleAddr  = {sample.pixel, sample.bin};

    // newest matching write wins
    assign baseCount = (s2Valid && (s2Addr == s1Addr)) ? s2Data :
                       (s3Valid && (s3Addr == s1Addr)) ? s3Data :
                       readData;

    // hold at full scale
    assign nextCount = (baseCount == '1) ? baseCount
                                         : baseCount + tdcHistPkg::count_t'(1);

    assign ownReq = '{
        writeEn:   s2Valid,
        writeAddr: s2Addr,
        writeData: s2Data,
        readEn:    accept,
        readAddr:  sampleAddr
    };

    // scanner owns both ports while it runs
    assign ramReq = scanBusy ? scanReq : ownReq;

    // pipeline valids
    always_ff @(posedge clk) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= accept;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    // pipeline payload
    always_ff @(posedge clk) begin
        s1Addr <= sampleAddr;
        s2Addr <= s1Addr;
        s2Data <= nextCount;
        s3Addr <= s2Addr;
        s3Data <= s2Data;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= histCtrlPkg::updIdle;
            drainCnt  <= 1'b0;
            scanStart <= 1'b0;
        end else begin
            scanStart <= 1'b0;
            case (state)
                histCtrlPkg::updIdle: begin
                    if (frameAccept) begin
                        state    <= histCtrlPkg::updDraining;
                        drainCnt <= 1'b0;
                    end else if (accept) begin
                        state <= histCtrlPkg::updAccumulating;
                    end
                end
                histCtrlPkg::updAccumulating: begin
                    if (frameAccept) begin
                        state    <= histCtrlPkg::updDraining;
                        drainCnt <= 1'b0;
                    end else if (!accept && !s1Valid && !s2Valid) begin
                        state <= histCtrlPkg::updIdle;
                    end
                end
                // two cycles for the last write to land
                histCtrlPkg::updDraining: begin
                    if (drainCnt) begin
                        state     <= histCtrlPkg::updScanning;
                        scanStart <= 1'b1;
                    end else begin
                        drainCnt <= 1'b1;
                    end
                end
                // scanBusy rises one cycle after scanStart
                histCtrlPkg::updScanning: begin
                    if (!scanBusy && !scanStart) begin
                        if (frameAccept) begin
                            state    <= histCtrlPkg::updDraining;
                            drainCnt <= 1'b0;
                        end else if (accept) begin
                            state <= histCtrlPkg::updAccumulating;
                        end else begin
                            state <= histCtrlPkg::updIdle;
                        end
                    end
                end
                default: begin
                    state <= histCtrlPkg::updIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/peakScanner.sv
`timescale 1ns/100ps
`default_nettype none

`include "tdcHist_consts.svh"

module peakScanner (
    input  wire logic               clk,
    input  wire logic               rstN,
    input  wire logic               scanStart,
    input  wire tdcHistPkg::count_t readData,
    output histCtrlPkg::ramReq_t    scanReq,
    output logic                    scanBusy,
    output logic                    peakValid,
    output tdcHistPkg::peak_t       peak
);

    histCtrlPkg::scanState_e state;

    // read address, walks pixels then bins
    tdcHistPkg::histAddr_t   addr;

    // read address one cycle late, also the clear address
    tdcHistPkg::histAddr_t   wrAddr;
    logic                    wrEn;
    logic                    rdPend;
    logic [1:0]              gapCnt;

    tdcHistPkg::count_t      maxCount;
    tdcHistPkg::binIdx_t     maxBin;

    tdcHistPkg::binIdx_t     dataBin;
    tdcHistPkg::pixelIdx_t   dataPixel;
    logic                    newMax;

    // bin and pixel of the data on readData
    assign dataBin   = wrAddr[`BIN_BITS-1:0];
    assign dataPixel = wrAddr[`ADDR_BITS-1:`BIN_BITS];

    // bin 0 restarts the search, strict compare keeps the lowest bin on a tie
    assign newMax = (dataBin == '0) || (readData > maxCount);

    assign scanReq = '{
        writeEn:   wrEn,
        writeAddr: wrAddr,
        writeData: '0,
        readEn:    state == histCtrlPkg::scanScanning,
        readAddr:  addr
    };

    // trailing write keeps the port until the last clear lands
    assign scanBusy = (state != histCtrlPkg::scanIdle) || wrEn;

    assign peak = '{
        pixel: dataPixel,
        bin:   maxBin,
        count: maxCount
    };

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state  <= histCtrlPkg::scanClearing;
            addr   <= '0;
            gapCnt <= '0;
        end else begin
            case (state)
                // zero the whole RAM once after reset
                histCtrlPkg::scanClearing: begin
                    addr <= addr + 1'b1;
                    if (addr == '1) begin
                        state <= histCtrlPkg::scanIdle;
                    end
                end
                histCtrlPkg::scanIdle: begin
                    if (scanStart) begin
                        state <= histCtrlPkg::scanScanning;
                    end
                end
                histCtrlPkg::scanScanning: begin
                    addr <= addr + 1'b1;
                    if (addr[`BIN_BITS-1:0] == '1) begin
                        state  <= histCtrlPkg::scanReporting;
                        gapCnt <= '0;
                    end
                end
                // last data, report, then one idle cycle
                histCtrlPkg::scanReporting: begin
                    gapCnt <= gapCnt + 1'b1;
                    if (gapCnt == 2'd2) begin
                        if (dataPixel == tdcHistPkg::pixelIdx_t'(`PIXEL_NUM - 1)) begin
                            state <= histCtrlPkg::scanIdle;
                            addr  <= '0;
                        end else begin
                            state <= histCtrlPkg::scanScanning;
                        end
                    end
                end
                default: begin
                    state <= histCtrlPkg::scanIdle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrEn      <= 1'b0;
            rdPend    <= 1'b0;
            peakValid <= 1'b0;
        end else begin
            wrEn      <= (state == histCtrlPkg::scanClearing)
                      || (state == histCtrlPkg::scanScanning);
            rdPend    <= state == histCtrlPkg::scanScanning;
            // last bin of a pixel just compared
            peakValid <= rdPend && (dataBin == '1);
        end
    end

    always_ff @(posedge clk) begin
        if ((state == histCtrlPkg::scanClearing) || (state == histCtrlPkg::scanScanning)) begin
            wrAddr <= addr;
        end
        // running max
        if (rdPend && newMax) begin
            maxCount <= readData;
            maxBin   <= dataBin;
        end
    end

endmodule

`default_nettype wire

// File: design/tdcHistTop.sv
`timescale 1ns/100ps
`default_nettype none

module tdcHistTop (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire tdcHistPkg::sample_t sample,
    input  wire logic                frameDone,
    output logic                     busy,
    output logic                     peakValid,
    output tdcHistPkg::peak_t        peak
);

    // RAM port after the controller's mux
    histCtrlPkg::ramReq_t ramReq;

    // scanner's request, forwarded while scanBusy
    histCtrlPkg::ramReq_t scanReq;

    tdcHistPkg::count_t   readData;
    logic                 scanStart;
    logic                 scanBusy;

    histUpdateFsm u_histUpdateFsm (
        .clk       (clk),
        .rstN      (rstN),
        .sample    (sample),
        .frameDone (frameDone),
        .readData  (readData),
        .scanReq   (scanReq),
        .scanBusy  (scanBusy),
        .ramReq    (ramReq),
        .scanStart (scanStart),
        .busy      (busy)
    );

    // clear sweep after reset, peak search per frame
    peakScanner u_peakScanner (
        .clk       (clk),
        .rstN      (rstN),
        .scanStart (scanStart),
        .readData  (readData),
        .scanReq   (scanReq),
        .scanBusy  (scanBusy),
        .peakValid (peakValid),
        .peak      (peak)
    );

    histRam u_histRam (
        .clk      (clk),
        .ramReq   (ramReq),
        .readData (readData)
    );

endmodule

`default_nettype wire

// File: verif/tdcHistTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "tdcHist_consts.svh"

module tdcHistTb;

    localparam int BinNum   = 1 << `BIN_BITS;
    localparam int CountMax = (1 << `COUNT_BITS) - 1;
    // clear sweep, six frame scans of 67 cycles per pixel, sample cycles, 4x margin
    localparam int ClearCycles   = 1 << `ADDR_BITS;
    localparam int ScanCycles    = `PIXEL_NUM * 67 + 4;
    localparam int SampleCycles  = 2500;
    localparam int TimeoutCycles = 4 * (ClearCycles + 6 * ScanCycles + SampleCycles);
    // two drain cycles and the scanStart cycle before 67 cycles per pixel
    localparam int FrameBusyCycles = 3 + `PIXEL_NUM * 67;

    logic                clk = 1'b0;
    logic                rstN;
    tdcHistPkg::sample_t sample;
    logic                frameDone;
    logic                busy;
    logic                peakValid;
    tdcHistPkg::peak_t   peak;

    integer seed        = 32'h0c62_8131;
    int     cycleCount  = 0;
    int     errorCount  = 0;
    int     reportCount = 0;
    int     passCount   = 0;
    int     failCount   = 0;
    // pixel whose report is due next
    int     nextPixel   = 0;
    // expected count per pixel and bin
    int     refCount [0:`PIXEL_NUM-1][0:BinNum-1];
    // high from frameDone until busy falls again
    logic   frameActive = 1'b0;

    tdcHistTop dut (
        .clk       (clk),
        .rstN      (rstN),
        .sample    (sample),
        .frameDone (frameDone),
        .busy      (busy),
        .peakValid (peakValid),
        .peak      (peak)
    );

    always #5 clk = ~clk;

    // largest count with the first maximum kept on a tie
    function automatic tdcHistPkg::peak_t expectedPeak(input int pixel);
        tdcHistPkg::peak_t result;
        int                bestBin;
        int                b;
        bestBin = 0;
        for (b = 1; b < BinNum; b++)
            if (refCount[pixel][b] > refCount[pixel][bestBin])
                bestBin = b;
        result.pixel = tdcHistPkg::pixelIdx_t'(pixel);
        result.bin   = tdcHistPkg::binIdx_t'(bestBin);
        result.count = tdcHistPkg::count_t'(refCount[pixel][bestBin]);
        return result;
    endfunction

    task automatic checkReport();
        tdcHistPkg::peak_t want;
        int                b;
        want = expectedPeak(nextPixel);
        if (peak.pixel !== want.pixel) begin
            $display("%0t: got a report for pixel %0d while pixel %0d was due",
                     $time, peak.pixel, want.pixel);
            errorCount++;
        end else begin
            if (peak.bin !== want.bin) begin
                $display("CHECK FAILED %0t peak.bin expected %0d actual %0d",
                         $time, want.bin, peak.bin);
                errorCount++;
            end
            if (peak.count !== want.count) begin
                $display("CHECK FAILED %0t peak.count expected %0d actual %0d",
                         $time, want.count, peak.count);
                errorCount++;
            end
        end
        // the scan zeroes every bin it reads
        for (b = 0; b < BinNum; b++)
            refCount[nextPixel][b] = 0;
        nextPixel = (nextPixel + 1) % `PIXEL_NUM;
        reportCount++;
    endtask

    // peak outputs sampled before the edge updates them
    always @(posedge clk) begin
        if (rstN && peakValid)
            checkReport();
    end

    // one strobe that counts only if busy is low
    task automatic driveSample(input int pixel, input int bin);
        sample.valid = 1'b1;
        sample.pixel = tdcHistPkg::pixelIdx_t'(pixel);
        sample.bin   = tdcHistPkg::binIdx_t'(bin);
        if (busy && !frameActive) begin
            $display("%0t: busy was high outside a frame scan and dropped a sample", $time);
            errorCount++;
        end
        if (!busy && refCount[pixel][bin] < CountMax)
            refCount[pixel][bin] = refCount[pixel][bin] + 1;
        @(negedge clk);
        sample.valid = 1'b0;
    endtask

    task automatic randomSample();
        int pixel;
        int bin;
        pixel = $unsigned($random(seed)) % `PIXEL_NUM;
        bin   = $unsigned($random(seed)) % BinNum;
        driveSample(pixel, bin);
    endtask

    // frameDone and a wait for the scan to finish
    task automatic runFrame(input bit dropWhileBusy);
        int startReports;
        int busyCycles;
        startReports = reportCount;
        busyCycles   = 0;
        while (busy)
            @(negedge clk);
        frameActive = 1'b1;
        frameDone   = 1'b1;
        @(negedge clk);
        frameDone = 1'b0;
        if (!busy) begin
            $display("%0t: frameDone was not accepted, busy stayed low", $time);
            errorCount++;
        end
        // strobes during drain and scan must be dropped
        while (busy) begin
            busyCycles++;
            if (dropWhileBusy)
                randomSample();
            else
                @(negedge clk);
        end
        frameActive = 1'b0;
        if (busyCycles != FrameBusyCycles) begin
            $display("%0t: busy stayed high for %0d cycles after frameDone instead of %0d",
                     $time, busyCycles, FrameBusyCycles);
            errorCount++;
        end
        if (reportCount - startReports != `PIXEL_NUM) begin
            $display("%0t: frame gave %0d peak reports instead of %0d",
                     $time, reportCount - startReports, `PIXEL_NUM);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("%0t: test %s ok", $time, name);
        end else begin
            failCount++;
            $display("%0t: test %s FAILED, %0d errors", $time, name, errorCount - errorsBefore);
        end
    endtask

    initial begin
        int errorsBefore;
        int i;
        rstN      = 1'b0;
        frameDone = 1'b0;
        sample    = '0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;

        // empty frame after the clear sweep
        errorsBefore = errorCount;
        while (busy)
            @(negedge clk);
        if (reportCount != 0) begin
            $display("%0t: peaks were reported during the clearing sweep", $time);
            errorCount++;
        end
        runFrame(1'b0);
        finishTest("empty frame", errorsBefore);

        // random hits with idle gaps
        errorsBefore = errorCount;
        for (i = 0; i < 600; i++) begin
            randomSample();
            if ($unsigned($random(seed)) % 4 == 0)
                @(negedge clk);
        end
        runFrame(1'b0);
        finishTest("random frame", errorsBefore);

        // same address every cycle and then two addresses alternating
        errorsBefore = errorCount;
        for (i = 0; i < 20; i++)
            driveSample(1, 10);
        for (i = 0; i < 30; i++)
            driveSample(2, 5 + (i % 2));
        runFrame(1'b0);
        finishTest("back-to-back hits", errorsBefore);

        // counter holds at full scale and equal maxima give the lower bin
        errorsBefore = errorCount;
        for (i = 0; i < 300; i++)
            driveSample(0, 33);
        for (i = 0; i < 14; i++)
            driveSample(3, (i % 2 == 0) ? 50 : 12);
        runFrame(1'b0);
        finishTest("saturation and tie break", errorsBefore);

        // two frames after the last one with strobes driven all through each scan
        errorsBefore = errorCount;
        for (i = 0; i < 150; i++)
            randomSample();
        runFrame(1'b1);
        for (i = 0; i < 150; i++)
            randomSample();
        runFrame(1'b1);
        finishTest("clear on read and dropped samples", errorsBefore);

        @(negedge clk);
        $display("tests ok %0d, tests failed %0d, check errors %0d",
                 passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: the run did not end within %0d cycles", TimeoutCycles);
            $display("Regression failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/tdcHistPkg.sv
design/histCtrlPkg.sv
design/histRam.sv
design/histUpdateFsm.sv
design/peakScanner.sv
design/tdcHistTop.sv
verif/tdcHistTb.sv

// File: Makefile
# Verilator simulation of the histogram engine testbench

VERILATOR ?= verilator
TOP       ?= tdcHistTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test: no result in $(LOG)"; exit 1; fi
	@echo "test: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
